/* run.sh */
#!/usr/bin/env bash
# Compile and run the vector lane testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vec_lane.f \
  --top-module tb_vec_lane -Mdir obj_dir -o tb_vec_lane
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_vec_lane > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tb_vec_lane.sv */
////////////////////////////////////////////////////////////
// Testbench for the vector lane with MaxVl 4. Runs stop at
// the first mismatch. Store data is checked in issue order
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_vec_lane;
  import vec_lane_pkg::*;

  localparam int unsigned MaxVl       = 4;
  localparam int unsigned QueueDepth  = 4;
  localparam int unsigned ClkPeriod   = 20;
  localparam int unsigned NrRandAlu   = 40;
  localparam int unsigned NrOverlap   = 6;
  // Stores, loads and ALU instructions over all phases
  localparam int unsigned NrOps       = 5 * NrVRegs + NrVRegs * MaxVl + 2 * NrRandAlu
                                        + NrOverlap * (MaxVl + 3);
  localparam int unsigned WaitLimit   = 16 * MaxVl + 32;
  localparam longint unsigned TimeoutNs = longint'(NrOps * WaitLimit + 32) * ClkPeriod;

  logic        clk_i;
  logic        rst_ni;
  lane_insn_t  insn_i;
  logic        insn_valid_i, insn_ready_o, insn_done_o;
  logic        ld_req_i, ld_gnt_o;
  ld_write_t   ld_data_i;
  elem_t       stu_operand_o;
  logic        stu_valid_o, stu_ready_i;

  elem_t       shadow [NrVRegs][MaxVl];
  elem_t       exp_q [$];
  logic [31:0] stim_rng, ready_rng;
  logic        stall_mode;
  logic        st_fire_q, ld_gnt_q, ld_busy_q;
  elem_t       st_data_q;
  int unsigned overlap_hits;

  vec_lane #(.MaxVl(MaxVl), .QueueDepth(QueueDepth)) DUT (
    .clk_i        (clk_i        ),
    .rst_ni       (rst_ni       ),
    .insn_i       (insn_i       ),
    .insn_valid_i (insn_valid_i ),
    .insn_ready_o (insn_ready_o ),
    .insn_done_o  (insn_done_o  ),
    .ld_req_i     (ld_req_i     ),
    .ld_data_i    (ld_data_i    ),
    .ld_gnt_o     (ld_gnt_o     ),
    .stu_operand_o(stu_operand_o),
    .stu_valid_o  (stu_valid_o  ),
    .stu_ready_i  (stu_ready_i  )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  // Element i of vd after one ALU instruction
  function automatic elem_t ref_elem(input lane_op_e op, input elem_t a, input elem_t b,
                                     input elem_t old, input int unsigned idx,
                                     input int unsigned vl);
    if (idx >= vl) begin
      return old;
    end
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return old;
    endcase
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %0t ns %s: got 32'h%08h, expected 32'h%08h",
                          $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Store port monitor and ready pattern
  ////////////////////////////////////////////////////////////

  // Handshake state seen at the rising edge
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_fire_q <= 1'b0;
      ld_gnt_q  <= 1'b0;
      ld_busy_q <= 1'b0;
      st_data_q <= '0;
    end else begin
      st_fire_q <= stu_valid_o && stu_ready_i;
      st_data_q <= stu_operand_o;
      ld_gnt_q  <= ld_gnt_o;
      // Grant landed while an instruction was already running
      ld_busy_q <= ld_gnt_o && !insn_ready_o;
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      if (st_fire_q) begin
        if (exp_q.size() == 0) begin
          abort_run("Store port delivered an element that no store asked for");
        end
        check_value("stu_operand_o", st_data_q, exp_q.pop_front());
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk_i);
      ready_rng   = xorshift(ready_rng);
      stu_ready_i = stall_mode ? ready_rng[9] : 1'b1;
    end
  end

  initial begin
    #(TimeoutNs);
    abort_run("Watchdog expired before all tests finished");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////

  task automatic wait_done();
    int unsigned waited;
    waited = 0;
    while (!insn_done_o) begin
      check_value("insn_ready_o", 32'(insn_ready_o), 32'd0);
      if (waited == WaitLimit) begin
        abort_run("insn_done_o did not pulse within the wait limit");
      end
      waited++;
      @(negedge clk_i);
    end
    check_value("insn_ready_o", 32'(insn_ready_o), 32'd1);
    @(negedge clk_i);
    check_value("insn_done_o", 32'(insn_done_o), 32'd0);
  endtask

  task automatic issue_insn(input lane_op_e op, input vreg_t vd, input vreg_t vs1,
                            input vreg_t vs2, input int unsigned vl);
    @(negedge clk_i);
    check_value("insn_ready_o", 32'(insn_ready_o), 32'd1);
    insn_i       = '{op: op, vd: vd, vs1: vs1, vs2: vs2, vl: vlen_t'(vl)};
    insn_valid_i = 1'b1;
    @(negedge clk_i);
    insn_valid_i = 1'b0;
    wait_done();
  endtask

  task automatic run_alu(input lane_op_e op, input vreg_t vd, input vreg_t vs1,
                         input vreg_t vs2, input int unsigned vl);
    elem_t res [MaxVl];
    for (int i = 0; i < MaxVl; i++) begin
      res[i] = ref_elem(op, shadow[vs1][i], shadow[vs2][i], shadow[vd][i], i, vl);
    end
    for (int i = 0; i < MaxVl; i++) begin
      shadow[vd][i] = res[i];
    end
    issue_insn(op, vd, vs1, vs2, vl);
  endtask

  task automatic run_store(input vreg_t vs1, input int unsigned vl);
    int unsigned waited;
    for (int i = 0; i < vl; i++) begin
      exp_q.push_back(shadow[vs1][i]);
    end
    issue_insn(OP_STORE, '0, vs1, '0, vl);
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == WaitLimit) begin
        abort_run("Store port did not deliver all elements of the store");
      end
      waited++;
      @(negedge clk_i);
    end
    check_value("stu_valid_o", 32'(stu_valid_o), 32'd0);
  endtask

  task automatic load_elem(input vreg_t vreg, input int unsigned idx, input elem_t data);
    int unsigned waited;
    @(negedge clk_i);
    ld_req_i  = 1'b1;
    ld_data_i = '{vreg: vreg, idx: vidx_t'(idx), data: data};
    waited    = 0;
    do begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitLimit) begin
        abort_run("Load request was never granted");
      end
    end while (!ld_gnt_q);
    ld_req_i = 1'b0;
    shadow[vreg][idx] = data;
    if (ld_busy_q) begin
      overlap_hits++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    lane_op_e    op;
    vreg_t       vd, vs1, vs2, r_ld;
    int unsigned vl;
    elem_t       ld_vals [MaxVl];
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    ld_req_i     = 1'b0;
    ld_data_i    = '0;
    stu_ready_i  = 1'b1;
    stall_mode   = 1'b0;
    stim_rng     = 32'he545;
    ready_rng    = xorshift(32'he545);
    overlap_hits = 0;
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < MaxVl; i++) begin
        shadow[r][i] = '0;
      end
    end
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Idle state and zeroed register file
    check_value("insn_ready_o", 32'(insn_ready_o), 32'd1);
    check_value("stu_valid_o", 32'(stu_valid_o), 32'd0);
    check_value("insn_done_o", 32'(insn_done_o), 32'd0);
    check_value("ld_gnt_o", 32'(ld_gnt_o), 32'd0);
    for (int r = 0; r < NrVRegs; r++) begin
      run_store(vreg_t'(r), MaxVl);
    end

    // Fill every register through the load port
    for (int r = 0; r < NrVRegs; r++) begin
      for (int i = 0; i < MaxVl; i++) begin
        load_elem(vreg_t'(r), i, next_rand());
      end
    end
    for (int r = 0; r < NrVRegs; r++) begin
      run_store(vreg_t'(r), MaxVl);
    end

    // Random ALU ops, full-length store shows the tail too
    for (int t = 0; t < NrRandAlu; t++) begin
      op  = lane_op_e'(3'(next_rand() % 5));
      vd  = vreg_t'(next_rand());
      vs1 = vreg_t'(next_rand());
      vs2 = vreg_t'(next_rand());
      vl  = next_rand() % MaxVl + 1;
      run_alu(op, vd, vs1, vs2, vl);
      run_store(vd, MaxVl);
    end
    for (int r = 0; r < NrVRegs; r++) begin
      run_store(vreg_t'(r), MaxVl);
    end

    // Store back-pressure
    stall_mode <= 1'b1;
    for (int r = 0; r < NrVRegs; r++) begin
      run_store(vreg_t'(r), next_rand() % MaxVl + 1);
    end
    stall_mode <= 1'b0;

    // Loads to an unrelated register while the ALU runs
    for (int t = 0; t < NrOverlap; t++) begin
      op   = lane_op_e'(3'(next_rand() % 5));
      vd   = vreg_t'(next_rand());
      vs1  = vreg_t'(next_rand());
      vs2  = vreg_t'(next_rand());
      r_ld = vreg_t'(next_rand());
      while (r_ld == vd || r_ld == vs1 || r_ld == vs2) begin
        r_ld = r_ld + vreg_t'(1);
      end
      for (int i = 0; i < MaxVl; i++) begin
        ld_vals[i] = next_rand();
      end
      fork
        run_alu(op, vd, vs1, vs2, MaxVl);
        begin
          for (int i = 0; i < MaxVl; i++) begin
            load_elem(r_ld, i, ld_vals[i]);
          end
        end
      join
      run_store(vd, MaxVl);
      run_store(r_ld, MaxVl);
    end
    if (overlap_hits == 0) begin
      abort_run("No load was granted while an ALU instruction was running");
    end
    for (int r = 0; r < NrVRegs; r++) begin
      run_store(vreg_t'(r), MaxVl);
    end

    $display("test passed");
    $finish;
  end

endmodule : tb_vec_lane

`default_nettype wire

/* vec_lane.f */
vec_lane_pkg.sv
vec_lane_sequencer.sv
vec_lane_vrf.sv
vec_lane_operand_queue.sv
vec_lane_alu.sv
vec_lane_writeback.sv
vec_lane.sv
tb_vec_lane.sv

/* vec_lane.sv */
////////////////////////////////////////////////////////////
// Single vector lane, one instruction in flight at a time
// MaxVl 1 to 16, QueueDepth at least 2
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_lane #(
  parameter int unsigned MaxVl      = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Sequencer port
  input  vec_lane_pkg::lane_insn_t insn_i,
  input  logic                     insn_valid_i,
  output logic                     insn_ready_o,
  output logic                     insn_done_o,
  // Load unit
  input  logic                     ld_req_i,
  input  vec_lane_pkg::ld_write_t  ld_data_i,
  output logic                     ld_gnt_o,
  // Store unit
  output vec_lane_pkg::elem_t      stu_operand_o,
  output logic                     stu_valid_o,
  input  logic                     stu_ready_i
);
  import vec_lane_pkg::*;

  vrf_addr_t   rd_addr_a, rd_addr_b;
  elem_t       rd_data_a, rd_data_b;
  vrf_write_t  vrf_wr;
  logic        vrf_wr_en;
  alu_entry_t  alu_meta, alu_push_entry, alu_entry;
  logic        alu_push, alu_space, alu_entry_valid, alu_pop;
  logic        stu_push, stu_space, stu_pop;
  alu_result_t alu_result;
  logic        alu_result_valid, alu_last_wb;

  ////////////////////////////////////////////////////////////
  // Decode and register file
  ////////////////////////////////////////////////////////////

  vec_lane_sequencer #(.MaxVl(MaxVl)) i_sequencer (
    .clk_i        (clk_i       ),
    .rst_ni       (rst_ni      ),
    .insn_i       (insn_i      ),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .insn_done_o  (insn_done_o ),
    .rd_addr_a_o  (rd_addr_a   ),
    .rd_addr_b_o  (rd_addr_b   ),
    .alu_space_i  (alu_space   ),
    .stu_space_i  (stu_space   ),
    .alu_push_o   (alu_push    ),
    .alu_meta_o   (alu_meta    ),
    .stu_push_o   (stu_push    ),
    .alu_last_wb_i(alu_last_wb )
  );

  vec_lane_vrf #(.MaxVl(MaxVl)) i_vrf (
    .clk_i      (clk_i    ),
    .rst_ni     (rst_ni   ),
    .rd_addr_a_i(rd_addr_a),
    .rd_addr_b_i(rd_addr_b),
    .rd_data_a_o(rd_data_a),
    .rd_data_b_o(rd_data_b),
    .wr_en_i    (vrf_wr_en),
    .wr_i       (vrf_wr   )
  );

  ////////////////////////////////////////////////////////////
  // Operand queues
  ////////////////////////////////////////////////////////////

  // Operands join the delayed metadata here
  always_comb begin
    alu_push_entry     = alu_meta;
    alu_push_entry.opa = rd_data_a;
    alu_push_entry.opb = rd_data_b;
  end

  vec_lane_operand_queue #(.QueueDepth(QueueDepth), .T(alu_entry_t)) i_alu_queue (
    .clk_i  (clk_i          ),
    .rst_ni (rst_ni         ),
    .push_i (alu_push       ),
    .data_i (alu_push_entry ),
    .pop_i  (alu_pop        ),
    .data_o (alu_entry      ),
    .valid_o(alu_entry_valid),
    .space_o(alu_space      )
  );

  assign stu_pop = stu_valid_o && stu_ready_i;

  vec_lane_operand_queue #(.QueueDepth(QueueDepth), .T(elem_t)) i_stu_queue (
    .clk_i  (clk_i        ),
    .rst_ni (rst_ni       ),
    .push_i (stu_push     ),
    .data_i (rd_data_a    ),
    .pop_i  (stu_pop      ),
    .data_o (stu_operand_o),
    .valid_o(stu_valid_o  ),
    .space_o(stu_space    )
  );

  ////////////////////////////////////////////////////////////
  // Execute and result
  ////////////////////////////////////////////////////////////

  vec_lane_alu i_alu (
    .clk_i         (clk_i           ),
    .rst_ni        (rst_ni          ),
    .entry_i       (alu_entry       ),
    .entry_valid_i (alu_entry_valid ),
    .pop_o         (alu_pop         ),
    .result_o      (alu_result      ),
    .result_valid_o(alu_result_valid)
  );

  vec_lane_writeback i_writeback (
    .clk_i        (clk_i           ),
    .rst_ni       (rst_ni          ),
    .alu_result_i (alu_result      ),
    .alu_valid_i  (alu_result_valid),
    .ld_req_i     (ld_req_i        ),
    .ld_data_i    (ld_data_i       ),
    .ld_gnt_o     (ld_gnt_o        ),
    .wr_en_o      (vrf_wr_en       ),
    .wr_o         (vrf_wr          ),
    .alu_last_wb_o(alu_last_wb     )
  );

endmodule : vec_lane

`default_nettype wire

/* vec_lane_alu.sv */
////////////////////////////////////////////////////////////
// Execute stage, one element per cycle with no stall input
// Results are registered and carry their target with them
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_lane_alu (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vec_lane_pkg::alu_entry_t  entry_i,
  input  logic                      entry_valid_i,
  output logic                      pop_o,
  output vec_lane_pkg::alu_result_t result_o,
  output logic                      result_valid_o
);
  import vec_lane_pkg::*;

  elem_t       res;
  alu_result_t result_q;
  logic        result_valid_q;

  // Write-back always takes ALU results, so every entry pops at once
  assign pop_o = entry_valid_i;

  always_comb begin
    unique case (entry_i.op)
      OP_ADD:  res = entry_i.opa + entry_i.opb;
      OP_SUB:  res = entry_i.opa - entry_i.opb;
      OP_AND:  res = entry_i.opa & entry_i.opb;
      OP_OR:   res = entry_i.opa | entry_i.opb;
      OP_XOR:  res = entry_i.opa ^ entry_i.opb;
      default: res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= entry_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (entry_valid_i) begin
      result_q <= '{vd: entry_i.vd, idx: entry_i.idx, last: entry_i.last, data: res};
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Stores are steered to the store queue by the sequencer
  a_no_store_op : assert property (@(posedge clk_i) disable iff (!rst_ni)
    entry_valid_i |-> entry_i.op != OP_STORE);

endmodule : vec_lane_alu

`default_nettype wire

/* vec_lane_operand_queue.sv */
////////////////////////////////////////////////////////////
// Circular FIFO, QueueDepth >= 2. space_o needs two free
// slots to cover one push already in flight
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_lane_operand_queue #(
  parameter int unsigned QueueDepth = 4,
  parameter type         T          = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic valid_o,
  output logic space_o
);

  localparam int unsigned PtrW = $clog2(QueueDepth);
  localparam int unsigned CntW = $clog2(QueueDepth + 1);

  T                mem_q [QueueDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      // Simultaneous push and pop leave the count alone
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + CntW'(1);
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - CntW'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign valid_o = cnt_q != '0;
  assign space_o = cnt_q <= CntW'(QueueDepth - 2);

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && !pop_i |-> cnt_q < CntW'(QueueDepth));

  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> valid_o);

endmodule : vec_lane_operand_queue

`default_nettype wire

/* vec_lane_pkg.sv */
////////////////////////////////////////////////////////////
// Types and sizes shared by every block of the vector lane
// Index and length widths follow MaxVlLimit, not MaxVl
////////////////////////////////////////////////////////////
`default_nettype none

package vec_lane_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned ElemWidth  = 32;
  localparam int unsigned NrVRegs    = 8;
  localparam int unsigned MaxVlLimit = 16;

  typedef logic [ElemWidth-1:0]               elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]         vreg_t;
  typedef logic [$clog2(MaxVlLimit)-1:0]      vidx_t;
  // Holds 1 to MaxVlLimit
  typedef logic [$clog2(MaxVlLimit+1)-1:0]    vlen_t;

  ////////////////////////////////////////////////////////////
  // Instructions
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_XOR   = 3'd4,
    OP_STORE = 3'd5
  } lane_op_e;

  typedef struct packed {
    lane_op_e op;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    vlen_t    vl;
  } lane_insn_t;

  ////////////////////////////////////////////////////////////
  // Datapath payloads
  ////////////////////////////////////////////////////////////

  // One element address in the register file
  typedef struct packed {
    vreg_t vreg;
    vidx_t idx;
  } vrf_addr_t;

  typedef struct packed {
    lane_op_e op;
    vreg_t    vd;
    vidx_t    idx;
    logic     last;
    elem_t    opa;
    elem_t    opb;
  } alu_entry_t;

  typedef struct packed {
    vreg_t vd;
    vidx_t idx;
    logic  last;
    elem_t data;
  } alu_result_t;

  typedef struct packed {
    vreg_t vreg;
    vidx_t idx;
    elem_t data;
  } ld_write_t;

  // Same layout as ld_write_t, used on the internal write port
  typedef struct packed {
    vreg_t vreg;
    vidx_t idx;
    elem_t data;
  } vrf_write_t;

endpackage : vec_lane_pkg

`default_nettype wire

/* vec_lane_sequencer.sv */
////////////////////////////////////////////////////////////
// Decode stage. One instruction at a time, one element read
// per cycle. Read data arrives one cycle after the address
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_lane_sequencer #(
  parameter int unsigned MaxVl = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  vec_lane_pkg::lane_insn_t insn_i,
  input  logic                     insn_valid_i,
  output logic                     insn_ready_o,
  output logic                     insn_done_o,
  output vec_lane_pkg::vrf_addr_t  rd_addr_a_o,
  output vec_lane_pkg::vrf_addr_t  rd_addr_b_o,
  input  logic                     alu_space_i,
  input  logic                     stu_space_i,
  output logic                     alu_push_o,
  output vec_lane_pkg::alu_entry_t alu_meta_o,
  output logic                     stu_push_o,
  input  logic                     alu_last_wb_i
);
  import vec_lane_pkg::*;

  lane_insn_t insn_q;
  alu_entry_t meta_q;
  vidx_t      cnt_q;
  logic       busy_q, issuing_q;
  logic       push_q, push_store_q, done_q;
  logic       accept, issue, is_store, last_elem, finish;

  assign accept    = insn_valid_i && !busy_q;
  assign is_store  = insn_q.op == OP_STORE;
  assign last_elem = vlen_t'(cnt_q) == insn_q.vl - vlen_t'(1);
  // Stall while the target queue cannot absorb one more read
  assign issue     = busy_q && issuing_q && (is_store ? stu_space_i : alu_space_i);
  // Stores end at the last read, ALU ops at the last write-back
  assign finish    = (issue && last_elem && is_store) || alu_last_wb_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      issuing_q    <= 1'b0;
      cnt_q        <= '0;
      push_q       <= 1'b0;
      push_store_q <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      push_q       <= issue;
      push_store_q <= is_store;
      done_q       <= finish;
      if (accept) begin
        busy_q    <= 1'b1;
        issuing_q <= 1'b1;
        cnt_q     <= '0;
      end else begin
        if (issue) begin
          // Wrap to zero so the idle read address stays in range
          cnt_q <= last_elem ? '0 : cnt_q + vidx_t'(1);
          if (last_elem) begin
            issuing_q <= 1'b0;
          end
        end
        if (finish) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Metadata travels one cycle behind the read address
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= insn_i;
    end
    if (issue) begin
      meta_q <= '{op: insn_q.op, vd: insn_q.vd, idx: cnt_q, last: last_elem,
                  opa: '0, opb: '0};
    end
  end

  assign insn_ready_o = !busy_q;
  assign insn_done_o  = done_q;
  assign rd_addr_a_o  = '{vreg: insn_q.vs1, idx: cnt_q};
  assign rd_addr_b_o  = '{vreg: insn_q.vs2, idx: cnt_q};
  assign alu_push_o   = push_q && !push_store_q;
  assign stu_push_o   = push_q && push_store_q;
  assign alu_meta_o   = meta_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Nothing new enters while reads of the running instruction remain
  a_no_accept_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> !issuing_q);

  a_vl_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (insn_i.vl != '0 && insn_i.vl <= MaxVl));

endmodule : vec_lane_sequencer

`default_nettype wire

/* vec_lane_vrf.sv */
////////////////////////////////////////////////////////////
// Register file slice, NrVRegs x MaxVl elements
// Registered reads, a write and read of one address in a
// cycle return the old data
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_lane_vrf #(
  parameter int unsigned MaxVl = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  vec_lane_pkg::vrf_addr_t  rd_addr_a_i,
  input  vec_lane_pkg::vrf_addr_t  rd_addr_b_i,
  output vec_lane_pkg::elem_t      rd_data_a_o,
  output vec_lane_pkg::elem_t      rd_data_b_o,
  input  logic                     wr_en_i,
  input  vec_lane_pkg::vrf_write_t wr_i
);
  import vec_lane_pkg::*;

  localparam int unsigned IdxW = (MaxVl > 1) ? $clog2(MaxVl) : 1;

  elem_t mem_q [NrVRegs][MaxVl];
  elem_t rd_data_a_q, rd_data_b_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < NrVRegs; r++) begin
        for (int e = 0; e < MaxVl; e++) begin
          mem_q[r][e] <= '0;
        end
      end
    end else if (wr_en_i) begin
      mem_q[wr_i.vreg][wr_i.idx[IdxW-1:0]] <= wr_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_a_q <= mem_q[rd_addr_a_i.vreg][rd_addr_a_i.idx[IdxW-1:0]];
    rd_data_b_q <= mem_q[rd_addr_b_i.vreg][rd_addr_b_i.idx[IdxW-1:0]];
  end

  assign rd_data_a_o = rd_data_a_q;
  assign rd_data_b_o = rd_data_b_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Sequencer counter and load unit both stay inside the slice
  a_rd_idx : assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_addr_a_i.idx < MaxVl && rd_addr_b_i.idx < MaxVl);

  a_wr_idx : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en_i |-> wr_i.idx < MaxVl);

endmodule : vec_lane_vrf

`default_nettype wire

/* vec_lane_writeback.sv */
////////////////////////////////////////////////////////////
// Result stage. ALU results own the write port, loads get
// the idle cycles. A load request must hold until granted
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_lane_writeback (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vec_lane_pkg::alu_result_t alu_result_i,
  input  logic                      alu_valid_i,
  input  logic                      ld_req_i,
  input  vec_lane_pkg::ld_write_t   ld_data_i,
  output logic                      ld_gnt_o,
  output logic                      wr_en_o,
  output vec_lane_pkg::vrf_write_t  wr_o,
  output logic                      alu_last_wb_o
);
  import vec_lane_pkg::*;

  // Fixed priority
  assign ld_gnt_o = ld_req_i && !alu_valid_i;
  assign wr_en_o  = alu_valid_i || ld_req_i;

  always_comb begin
    if (alu_valid_i) begin
      wr_o.vreg = alu_result_i.vd;
      wr_o.idx  = alu_result_i.idx;
      wr_o.data = alu_result_i.data;
    end else begin
      wr_o.vreg = ld_data_i.vreg;
      wr_o.idx  = ld_data_i.idx;
      wr_o.data = ld_data_i.data;
    end
  end

  // Lands in this cycle, the sequencer reports done on the next
  assign alu_last_wb_o = alu_valid_i && alu_result_i.last;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // Load side keeps its request and payload while it waits
  a_ld_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ld_req_i && !ld_gnt_o |=> ld_req_i && $stable(ld_data_i));

endmodule : vec_lane_writeback

`default_nettype wire
